//--- colmix.f
rtl/colmix_pkg.sv
rtl/pxl_priority.sv
rtl/pal_ram.sv
rtl/pal_fetch.sv
rtl/colmix_top.sv
verif/colmix_checker.sv
verif/colmix_tb.sv

//--- verif/colmix_tb.sv
/* Colour mixer testbench
   Directed tests of priority, blanking and pipeline order against a palette model */

`timescale 1ns/1ps

module colmix_tb;

    localparam int score_rows = 48;     // DUT default
    localparam int max_cycles = 4000;   // Fill 1536 clk, bus tests ~70, ~70 pixel periods

    // Pixel inputs {obj, scr1, scr2col, scr2_pxl, scr2enb, v, gfx_en}
    typedef logic [36:0] pixel_t;

    logic                  clk;
    logic                  rst;
    logic                  pxl_cen;
    logic                  lhbl;
    logic                  lvbl;
    colmix_pkg::pal_addr_t main_addr;
    colmix_pkg::cpu_data_t main_dout;
    logic                  main_rnw;
    logic                  pal_cs;
    colmix_pkg::cpu_data_t main_din;
    colmix_pkg::pal_idx_t  scr1_pxl;
    logic [2:0]            scr2col;
    logic [3:0]            scr2_pxl;
    colmix_pkg::pal_idx_t  obj_pxl;
    logic                  scr2enb;
    colmix_pkg::vcount_t   v;
    logic [3:0]            gfx_en;
    colmix_pkg::color_t    red;
    colmix_pkg::color_t    green;
    colmix_pkg::color_t    blue;
    logic [2:0]            cen_cnt;   // Strobe divider
    int unsigned           cycles;
    colmix_pkg::cpu_data_t pal_model [colmix_pkg::pal_depth];   // Expected palette

    colmix_top i_dut (.*);

    bind colmix_top colmix_checker i_checker (.*);

    always #50 clk = ~clk;

    // One strobe every 8 clk
    always @(posedge clk) begin
        if (rst) begin
            cen_cnt <= 3'd0;
            pxl_cen <= 1'b0;
        end else begin
            cen_cnt <= cen_cnt + 3'd1;
            pxl_cen <= (cen_cnt == 3'd7);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: run passed %0d clk cycles without finishing", max_cycles);
            $display("ERRORS FOUND");
            $fatal(1, "Testbench timed out");
        end
    end

    // Stop at the first checker assertion failure
    always @(posedge clk) begin
        if (i_dut.i_checker.fail_count != 0) begin
            $display("Checker assertion failed before %0t", $time);
            $display("ERRORS FOUND");
            $fatal(1, "Assertion failure");
        end
    end

    task automatic check_color(input string name, input colmix_pkg::color_t act,
                               input colmix_pkg::color_t want);
        if (act !== want) begin
            $display("mismatch at %0t: %s = %h, expected %h", $time, name, act, want);
            $display("ERRORS FOUND");
            $fatal(1, "Colour component check failed");
        end
    endtask

    task automatic check_byte(input string name, input colmix_pkg::cpu_data_t act,
                              input colmix_pkg::cpu_data_t want);
        if (act !== want) begin
            $display("mismatch at %0t: %s = %h, expected %h", $time, name, act, want);
            $display("ERRORS FOUND");
            $fatal(1, "Palette byte check failed");
        end
    endtask

    // Returns on the edge where the DUT takes a strobe
    task automatic next_strobe();
        do begin
            @(posedge clk);
        end while (pxl_cen !== 1'b1);
    endtask

    task automatic cpu_write(input colmix_pkg::pal_addr_t a, input colmix_pkg::cpu_data_t d);
        @(posedge clk);
        main_addr <= a;
        main_dout <= d;
        main_rnw  <= 1'b0;
        pal_cs    <= 1'b1;
        pal_model[a] = d;
    endtask

    task automatic cpu_read_check(input colmix_pkg::pal_addr_t a);
        @(posedge clk);
        main_addr <= a;
        main_rnw  <= 1'b1;
        pal_cs    <= 1'b1;
        @(posedge clk);        // RAM registers the byte here
        @(posedge clk);
        check_byte("main_din", main_din, pal_model[a]);
    endtask

    task automatic bus_idle();
        @(posedge clk);
        pal_cs   <= 1'b0;
        main_rnw <= 1'b1;
    endtask

    // Winning {layer, index} from the priority rules
    function automatic logic [8:0] pick_layer(input pixel_t p);
        colmix_pkg::pal_idx_t obj;
        colmix_pkg::pal_idx_t scr1;
        logic [2:0]           s2col;
        logic [3:0]           s2pxl;
        logic                 s2enb;
        colmix_pkg::vcount_t  vv;
        logic [3:0]           en;
        logic                 obj_vis;
        logic                 scr1_vis;
        {obj, scr1, s2col, s2pxl, s2enb, vv, en} = p;
        obj_vis  = (obj[3:0] != 4'd0) && en[3];
        scr1_vis = (scr1[3:0] != 4'd0) && en[0];
        if (obj_vis && !(scr1_vis && scr1[7:6] == 2'b11 && scr1[3]))
            return {1'b0, obj};
        else if (s2enb || scr1[7:6] != 2'b00 || scr1_vis)
            return {1'b1, scr1};
        else
            return {1'b1, s2col[2:1], vv < score_rows, s2col[0], s2pxl};   // Scroll 2 index
    endfunction

    function automatic logic [14:0] model_color(input logic [8:0] li);
        return {pal_model[{li[8], colmix_pkg::comp_red, li[7:0]}][4:0],
                pal_model[{li[8], colmix_pkg::comp_green, li[7:0]}][4:0],
                pal_model[{li[8], colmix_pkg::comp_blue, li[7:0]}][4:0]};
    endfunction

    // Index with a non-zero colour nibble
    function automatic colmix_pkg::pal_idx_t rand_vis();
        return {4'($urandom_range(15, 0)), 4'($urandom_range(15, 1))};
    endfunction

    // Scroll 2 fields and v are random
    function automatic pixel_t make_pixel(input colmix_pkg::pal_idx_t obj,
            input colmix_pkg::pal_idx_t scr1, input logic s2enb, input logic [3:0] en);
        return {obj, scr1, 3'($urandom_range(7, 0)), 4'($urandom_range(15, 0)), s2enb,
                9'($urandom_range(511, 0)), en};
    endfunction

    task automatic drive_pixel(input pixel_t p);
        {obj_pxl, scr1_pxl, scr2col, scr2_pxl, scr2enb, v, gfx_en} <= p;
    endtask

    task automatic compare_rgb(input logic [14:0] want);
        check_color("red", red, want[14:10]);
        check_color("green", green, want[9:5]);
        check_color("blue", blue, want[4:0]);
    endtask

    // One pixel through the pipe, hb/vb apply when it is shown
    task automatic check_pixel(input pixel_t p, input logic hb, input logic vb);
        logic [14:0] want;
        next_strobe();
        drive_pixel(p);
        want = (hb && vb) ? model_color(pick_layer(p)) : 15'd0;
        next_strobe();           // Pixel sampled
        lhbl <= hb;
        lvbl <= vb;
        next_strobe();           // Pixel shown
        @(posedge clk);
        lhbl <= 1'b1;
        lvbl <= 1'b1;
        compare_rgb(want);
    endtask

    task automatic test_palette_access();
        colmix_pkg::pal_addr_t addrs [16];
        for (int i = 0; i < 16; i++) begin
            addrs[i] = 11'($urandom_range(2047, 0));
            cpu_write(addrs[i], 8'($urandom_range(255, 0)));
        end
        for (int i = 0; i < 16; i++) begin
            cpu_read_check(addrs[i]);
        end
        bus_idle();
    endtask

    task automatic fill_palette();
        for (int a = 0; a < colmix_pkg::pal_depth; a++) begin
            if (a[9:8] != 2'd3) begin                  // Skip the unused bank
                cpu_write(11'(a), 8'($urandom_range(255, 0)));
            end
        end
        bus_idle();
    endtask

    task automatic test_object_priority();
        for (int i = 0; i < 4; i++) begin
            check_pixel(make_pixel(rand_vis(), rand_vis() & 8'h7F, 1'b0, 4'hF), 1'b1, 1'b1);
        end
    endtask

    task automatic test_override_masking();
        for (int i = 0; i < 2; i++) begin
            check_pixel(make_pixel(rand_vis(), rand_vis() | 8'hC8, 1'b0, 4'hF), 1'b1, 1'b1);
            check_pixel(make_pixel(rand_vis(), rand_vis() & 8'h3F, 1'b0, 4'h7), 1'b1, 1'b1);
            check_pixel(make_pixel(rand_vis(), rand_vis() & 8'h3F, 1'b0, 4'h6), 1'b1, 1'b1);
        end
    endtask

    task automatic test_scr2_fallback();
        colmix_pkg::vcount_t rows [4] = '{9'd0, 9'd47, 9'd48, 9'd300};   // Around the score edge
        for (int i = 0; i < 4; i++) begin
            check_pixel({16'h0000, 3'($urandom_range(7, 0)), 4'($urandom_range(15, 0)),
                         1'b0, rows[i], 4'hF}, 1'b1, 1'b1);
        end
    endtask

    task automatic test_blanking();
        check_pixel(make_pixel(rand_vis(), 8'h00, 1'b0, 4'hF), 1'b0, 1'b1);
        check_pixel(make_pixel(rand_vis(), 8'h00, 1'b0, 4'hF), 1'b1, 1'b0);
        check_pixel(make_pixel(rand_vis(), 8'h00, 1'b0, 4'hF), 1'b1, 1'b1);
    endtask

    // Back-to-back strobes, pixel k comes out at strobe k+2
    task automatic test_pipeline(input int n);
        logic [14:0] want_q [$];
        pixel_t      p;
        for (int k = 0; k < n + 2; k++) begin
            next_strobe();
            if (k < n) begin
                p = {32'($urandom()), 5'($urandom_range(31, 0))};
                drive_pixel(p);
                want_q.push_back(model_color(pick_layer(p)));
            end
            @(posedge clk);
            if (k >= 2) begin
                compare_rgb(want_q.pop_front());
            end
        end
    endtask

    initial begin
        void'($urandom(32'h8942));
        clk       = 1'b0;
        rst       = 1'b1;
        pxl_cen   = 1'b0;
        lhbl      = 1'b1;
        lvbl      = 1'b1;
        main_addr = '0;
        main_dout = '0;
        main_rnw  = 1'b1;
        pal_cs    = 1'b0;
        scr1_pxl  = '0;
        scr2col   = '0;
        scr2_pxl  = '0;
        obj_pxl   = '0;
        scr2enb   = 1'b0;
        v         = '0;
        gfx_en    = 4'hF;
        cycles    = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        test_palette_access();
        fill_palette();
        test_object_priority();
        test_override_masking();
        test_scr2_fallback();
        test_blanking();
        test_pipeline(16);
        if (i_dut.i_checker.fail_count != 0) begin
            $display("%0d assertion failures in the checker", i_dut.i_checker.fail_count);
            $display("ERRORS FOUND");
            $fatal(1, "Assertion failures");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

//--- verif/colmix_checker.sv
/* Colour mixer checker
   Assertions on reset, blanking and palette bank range */

`timescale 1ns/1ps

module colmix_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  pxl_cen,
    input logic                  lhbl,
    input logic                  lvbl,
    input colmix_pkg::pal_addr_t vid_addr,
    input colmix_pkg::color_t    red,
    input colmix_pkg::color_t    green,
    input colmix_pkg::color_t    blue
);

    int unsigned fail_count = 0;   // Failed assertions so far
    logic        black;

    assign black = (red === '0) && (green === '0) && (blue === '0);   // X counts as not black

    // Outputs cleared by reset
    reset_black: assert property (@(posedge clk) rst |=> black)
        else begin
            $error("Colour output not black during reset");
            fail_count++;
        end

    // Strobe taken in blanking gives black for the whole next pixel
    blank_black: assert property (@(posedge clk) disable iff (rst)
        (pxl_cen && !(lhbl && lvbl)) |=> black)
        else begin
            $error("Colour output not black after a blanked strobe");
            fail_count++;
        end

    // Bank 3 is unused
    bank_range: assert property (@(posedge clk) disable iff (rst)
        vid_addr[colmix_pkg::pal_comp_hi:colmix_pkg::pal_comp_lo] != 2'd3)
        else begin
            $error("Video side addressed palette bank 3");
            fail_count++;
        end

endmodule

//--- rtl/colmix_top.sv
/* Colour mixing stage
   Layer priority, palette lookup and CPU access to the palette RAM */

`timescale 1ns/1ps

module colmix_top #(
    parameter int score_rows = 48
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  logic                  lhbl,
    input  logic                  lvbl,
    // CPU bus
    input  colmix_pkg::pal_addr_t main_addr,
    input  colmix_pkg::cpu_data_t main_dout,
    input  logic                  main_rnw,
    input  logic                  pal_cs,
    output colmix_pkg::cpu_data_t main_din,
    // Layer pixels
    input  colmix_pkg::pal_idx_t  scr1_pxl,
    input  logic [2:0]            scr2col,
    input  logic [3:0]            scr2_pxl,
    input  colmix_pkg::pal_idx_t  obj_pxl,
    input  logic                  scr2enb,
    input  colmix_pkg::vcount_t   v,
    input  logic [3:0]            gfx_en,   // Debug enables
    // Colour out
    output colmix_pkg::color_t    red,
    output colmix_pkg::color_t    green,
    output colmix_pkg::color_t    blue
);

    logic                  pal_we;
    colmix_pkg::layer_e    sel;
    colmix_pkg::pal_idx_t  pal_base;
    colmix_pkg::pal_addr_t vid_addr;
    colmix_pkg::cpu_data_t vid_dout;

    assign pal_we = pal_cs & ~main_rnw;   // Write when selected and not reading

    pxl_priority #(
        .score_rows (score_rows)
    ) u_priority (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .scr1_pxl (scr1_pxl),
        .scr2col  (scr2col),
        .scr2_pxl (scr2_pxl),
        .obj_pxl  (obj_pxl),
        .scr2enb  (scr2enb),
        .v        (v),
        .gfx_en   (gfx_en),
        .sel      (sel),
        .pal_base (pal_base)
    );

    pal_fetch u_fetch (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .sel      (sel),
        .pal_base (pal_base),
        .vid_dout (vid_dout),
        .vid_addr (vid_addr),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

    pal_ram u_pal_ram (
        .clk      (clk),
        .cpu_addr (main_addr),
        .cpu_we   (pal_we),
        .cpu_din  (main_dout),
        .vid_addr (vid_addr),
        .cpu_dout (main_din),
        .vid_dout (vid_dout)
    );

endmodule

//--- rtl/pal_fetch.sv
/* Palette component fetch
   Reads red, green and blue in turn each pixel and drives the blanked colour */

`timescale 1ns/1ps

module pal_fetch (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  logic                  lhbl,       // Horizontal blank, active low
    input  logic                  lvbl,       // Vertical blank, active low
    input  colmix_pkg::layer_e    sel,
    input  colmix_pkg::pal_idx_t  pal_base,
    input  colmix_pkg::cpu_data_t vid_dout,
    output colmix_pkg::pal_addr_t vid_addr,
    output colmix_pkg::color_t    red,
    output colmix_pkg::color_t    green,
    output colmix_pkg::color_t    blue
);

    logic [2:0]         sub;      // Clock count inside the pixel period
    logic [1:0]         comp;     // Component bank being read
    colmix_pkg::color_t pre_r;
    colmix_pkg::color_t pre_g;
    colmix_pkg::color_t pre_b;
    logic               blank;

    assign blank = !lhbl || !lvbl;

    // Restarts on the strobe, holds at 7 for long pixel periods
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sub <= 3'd0;
        end else if (pxl_cen) begin
            sub <= 3'd0;
        end else if (sub != 3'd7) begin
            sub <= sub + 3'd1;
        end
    end

    // Two clocks per bank, blue stays addressed after sub 4
    always_comb begin
        if (sub < 3'd2) begin
            comp = colmix_pkg::comp_red;
        end else if (sub < 3'd4) begin
            comp = colmix_pkg::comp_green;
        end else begin
            comp = colmix_pkg::comp_blue;   // Bank 3 never reached
        end
    end

    assign vid_addr = {sel, comp, pal_base};

    // RAM data is one clock late, so take it on the odd counts
    always_ff @(posedge clk) begin
        case (sub)
            3'd1:    pre_r <= vid_dout[4:0];
            3'd3:    pre_g <= vid_dout[4:0];
            3'd5:    pre_b <= vid_dout[4:0];
            default: ;
        endcase
    end

    // Previous pixel goes out as the new one starts
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (pxl_cen) begin
            if (blank) begin
                red   <= '0;   // Black outside the active area
                green <= '0;
                blue  <= '0;
            end else begin
                red   <= pre_r;
                green <= pre_g;
                blue  <= pre_b;
            end
        end
    end

endmodule

//--- rtl/pal_ram.sv
/* Palette RAM, 2048 bytes
   CPU read/write port and a read-only video port, both registered */

`timescale 1ns/1ps

module pal_ram (
    input  logic                  clk,
    input  colmix_pkg::pal_addr_t cpu_addr,
    input  logic                  cpu_we,
    input  colmix_pkg::cpu_data_t cpu_din,
    input  colmix_pkg::pal_addr_t vid_addr,
    output colmix_pkg::cpu_data_t cpu_dout,
    output colmix_pkg::cpu_data_t vid_dout
);

    colmix_pkg::cpu_data_t mem [colmix_pkg::pal_depth];

    // Power-up value of the read registers
    colmix_pkg::cpu_data_t cpu_q = '0;
    colmix_pkg::cpu_data_t vid_q = '0;

    // CPU port
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;
        end
        cpu_q <= mem[cpu_addr];    // Old data on a write cycle
    end

    // Video port, read only
    always_ff @(posedge clk) begin
        vid_q <= mem[vid_addr];
    end

    assign cpu_dout = cpu_q;
    assign vid_dout = vid_q;

endmodule

//--- rtl/pxl_priority.sv
/* Layer priority for the colour mixer
   Picks the winning layer and palette index at each pixel strobe */

`timescale 1ns/1ps

module pxl_priority #(
    parameter int score_rows = 48          // Lines above this are the score area
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  colmix_pkg::pal_idx_t    scr1_pxl,
    input  logic [2:0]              scr2col,
    input  logic [3:0]              scr2_pxl,
    input  colmix_pkg::pal_idx_t    obj_pxl,
    input  logic                    scr2enb,
    input  colmix_pkg::vcount_t     v,
    input  logic [3:0]              gfx_en,   // Debug layer enables
    output colmix_pkg::layer_e      sel,
    output colmix_pkg::pal_idx_t    pal_base
);

    logic                 obj_blank;
    logic                 scr1_blank;
    logic                 scr1_wins;
    logic                 score_row;
    logic                 scr1_pick;
    colmix_pkg::pal_idx_t scr2_idx;
    colmix_pkg::pal_idx_t scr_idx;

    // Colour 0 is transparent on both layers
    assign obj_blank  = (obj_pxl[3:0] == 4'd0) || !gfx_en[3];   // Object hidden by debug bit 3
    assign scr1_blank = (scr1_pxl[3:0] == 4'd0) || !gfx_en[0]; // Scroll 1 hidden by bit 0

    // Scroll 1 tiles with both top bits and bit 3 set sit above sprites
    assign scr1_wins = !scr1_blank && (scr1_pxl[7:6] == 2'b11) && scr1_pxl[3];

    // Score area flag goes into the scroll 2 index
    assign score_row = v < colmix_pkg::vcount_t'(score_rows);

    // Scroll 2 index layout
    assign scr2_idx = {scr2col[2:1], score_row, scr2col[0], scr2_pxl};

    // Scroll 1 keeps the index when enabled by the game or when it is opaque
    assign scr1_pick = scr2enb || scr1_pxl[7] || scr1_pxl[6] || !scr1_blank;
    assign scr_idx   = scr1_pick ? scr1_pxl : scr2_idx;

    // Registered once per pixel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel      <= colmix_pkg::layer_obj;
            pal_base <= '0;
        end else if (pxl_cen) begin
            if (obj_blank || scr1_wins) begin
                sel      <= colmix_pkg::layer_scr;   // Background bank
                pal_base <= scr_idx;
            end else begin
                sel      <= colmix_pkg::layer_obj;   // Sprite on top
                pal_base <= obj_pxl;
            end
        end
    end

endmodule

//--- rtl/colmix_pkg.sv
/* Colour mixer shared types
   Vector widths, layer select and palette RAM layout */

package colmix_pkg;

    // Palette RAM address, {layer, component, index}
    typedef logic [10:0] pal_addr_t;

    typedef logic [7:0] pal_idx_t;   // Palette index carried by a layer pixel
    typedef logic [4:0] color_t;     // One 5-bit colour component
    typedef logic [7:0] cpu_data_t;  // CPU data byte
    typedef logic [8:0] vcount_t;    // Vertical line count

    // Layer select, top bit of the palette address
    typedef enum logic {
        layer_obj = 1'b0,
        layer_scr = 1'b1
    } layer_e;

    // Component bank numbers, address bits 9:8
    localparam logic [1:0] comp_red   = 2'd0;
    localparam logic [1:0] comp_green = 2'd1;
    localparam logic [1:0] comp_blue  = 2'd2;
    // Bank 3 is never addressed by the video side

    // Field positions inside pal_addr_t
    localparam int pal_layer_bit = 10;
    localparam int pal_comp_hi   = 9;
    localparam int pal_comp_lo   = 8;

    // Palette size in bytes
    localparam int pal_depth = 2048;

endpackage
